// ==== common/huf_seq_pkg.sv ====
// shared parameters of the sequence descriptor store.
// compression mode, window size and prefix mode enums.
// descriptor and header type structs.

package huf_seq_pkg;

   // default table depth and id width.
   localparam int SEQID_NUM   = 8;
   localparam int SEQID_WIDTH = 3;

   typedef enum logic [2:0] {
      NONE  = 3'd0,
      XP9   = 3'd1,
      XP10  = 3'd2,
      GZIP  = 3'd3,
      ZLIB  = 3'd4,
      CHU4K = 3'd5,
      CHU8K = 3'd6
   } comp_mode_e;

   typedef enum logic [2:0] {
      WIN_4K  = 3'd0,
      WIN_8K  = 3'd1,
      WIN_16K = 3'd2,
      WIN_32K = 3'd3,
      WIN_64K = 3'd4
   } win_size_e;

   typedef enum logic [1:0] {
      NO_PREFIX     = 2'd0,
      USER_PREFIX   = 2'd1,
      PREDEF_PREFIX = 2'd2
   } prefix_mode_e;

   // one table entry, 41 bits.
   typedef struct packed {
      comp_mode_e   comp_mode;
      win_size_e    lz77_win_size;
      prefix_mode_e xp10_prefix_mode;
      logic         predet_mem_mask;
      logic [31:0]  raw_crc;
   } seq_desc_t;

   // header type word, 8 bits.
   typedef struct packed {
      comp_mode_e   comp_mode;
      win_size_e    lz77_win_size;
      prefix_mode_e xp10_prefix_mode;
   } hdr_type_t;

endpackage

// ==== hw/seq_admit.sv ====
// frame start admission for the sequence id table.
// lowest free id allocation, descriptor write and reject counter.
// crc update forwarding.

`timescale 1ns/1ps

module seq_admit #(
   parameter int SEQID_NUM   = huf_seq_pkg::SEQID_NUM,
   parameter int SEQID_WIDTH = huf_seq_pkg::SEQID_WIDTH
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   frame_start,
   input  huf_seq_pkg::seq_desc_t start_desc,
   input  logic                   crc_in_vld,
   input  logic [SEQID_WIDTH-1:0] crc_in_seq_id,
   input  logic [31:0]            crc_in_value,
   input  logic [SEQID_NUM-1:0]   seq_vld,
   output logic                   wr_vld,
   output logic [SEQID_WIDTH-1:0] wr_seq_id,
   output huf_seq_pkg::seq_desc_t wr_desc,
   output logic                   crc_vld,
   output logic [SEQID_WIDTH-1:0] crc_seq_id,
   output logic [31:0]            crc_value,
   output logic                   alloc_vld,
   output logic [SEQID_WIDTH-1:0] alloc_seq_id,
   output logic [15:0]            rej_cnt
);

   logic                   free_found;
   logic [SEQID_WIDTH-1:0] free_id;

   // priority encoder over the free entries, lowest index wins.
   always_comb begin
      free_found = 1'b0;
      free_id    = '0;
      for (int i = SEQID_NUM - 1; i >= 0; i--) begin
         if (!seq_vld[i]) begin
            free_found = 1'b1;
            free_id    = SEQID_WIDTH'(i);
         end
      end
   end

   assign alloc_vld    = frame_start && free_found;
   assign alloc_seq_id = free_id;

   // an admitted start is a full table write.
   assign wr_vld    = alloc_vld;
   assign wr_seq_id = free_id;
   assign wr_desc   = start_desc;

   // crc strobe goes straight to the table.
   assign crc_vld    = crc_in_vld;
   assign crc_seq_id = crc_in_seq_id;
   assign crc_value  = crc_in_value;

   // saturating count of starts that found the table full.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rej_cnt <= '0;
      end else if (frame_start && !free_found && (rej_cnt != 16'hffff)) begin
         rej_cnt <= rej_cnt + 16'd1;
      end
   end

endmodule

// ==== seq_table/seq_id_table.sv ====
// sequence id table with one descriptor and valid bit per entry.
// full write, crc only update and release.
// two lookup ports with prefix mode masking.

`timescale 1ns/1ps

module seq_id_table #(
   parameter int SEQID_NUM   = huf_seq_pkg::SEQID_NUM,
   parameter int SEQID_WIDTH = huf_seq_pkg::SEQID_WIDTH
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   wr_vld,
   input  logic [SEQID_WIDTH-1:0] wr_seq_id,
   input  huf_seq_pkg::seq_desc_t wr_desc,
   input  logic                   crc_vld,
   input  logic [SEQID_WIDTH-1:0] crc_seq_id,
   input  logic [31:0]            crc_value,
   input  logic                   rel_vld,
   input  logic [SEQID_WIDTH-1:0] rel_seq_id,
   input  logic [SEQID_WIDTH-1:0] lk_short_id,
   input  logic [SEQID_WIDTH-1:0] lk_long_id,
   output logic [SEQID_NUM-1:0]   seq_vld,
   output huf_seq_pkg::seq_desc_t lk_short_desc,
   output huf_seq_pkg::seq_desc_t lk_long_desc,
   output logic                   lk_short_vld,
   output logic                   lk_long_vld
);

   import huf_seq_pkg::*;

   seq_desc_t            desc_mem [SEQID_NUM];
   logic [SEQID_NUM-1:0] entry_vld;

   // prefix mode is only meaningful with the predetermined memory mask.
   function automatic seq_desc_t mask_prefix(input seq_desc_t d);
      seq_desc_t m;
      m = d;
      if (!d.predet_mem_mask) begin
         m.xp10_prefix_mode = NO_PREFIX;
      end
      return m;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < SEQID_NUM; i++) begin
            desc_mem[i] <= '0;
         end
         entry_vld <= '0;
      end else begin
         if (wr_vld) begin
            desc_mem[wr_seq_id]  <= wr_desc;
            entry_vld[wr_seq_id] <= 1'b1;
         end
         // crc update keeps the valid bit as it is.
         if (crc_vld) begin
            desc_mem[crc_seq_id].raw_crc <= crc_value;
         end
         // last assignment, so release beats a write to the same id.
         if (rel_vld) begin
            entry_vld[rel_seq_id] <= 1'b0;
         end
      end
   end

   assign seq_vld = entry_vld;

   // zero cycle lookups.
   always_comb begin
      lk_short_desc = mask_prefix(desc_mem[lk_short_id]);
      lk_long_desc  = mask_prefix(desc_mem[lk_long_id]);
      lk_short_vld  = entry_vld[lk_short_id];
      lk_long_vld   = entry_vld[lk_long_id];
   end

endmodule

// ==== hw/hdr_builder.sv ====
// header builder with a two stage pipeline.
// registers request ids, looks them up and packs header type words,
// the short entry crc and an error flag.

`timescale 1ns/1ps

module hdr_builder #(
   parameter int SEQID_WIDTH = huf_seq_pkg::SEQID_WIDTH
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   hdr_req,
   input  logic [SEQID_WIDTH-1:0] short_seq_id,
   input  logic [SEQID_WIDTH-1:0] long_seq_id,
   input  huf_seq_pkg::seq_desc_t lk_short_desc,
   input  huf_seq_pkg::seq_desc_t lk_long_desc,
   input  logic                   lk_short_vld,
   input  logic                   lk_long_vld,
   output logic [SEQID_WIDTH-1:0] lk_short_id,
   output logic [SEQID_WIDTH-1:0] lk_long_id,
   output logic                   hdr_vld,
   output huf_seq_pkg::hdr_type_t hdr_short,
   output huf_seq_pkg::hdr_type_t hdr_long,
   output logic [31:0]            hdr_crc,
   output logic                   hdr_err
);

   import huf_seq_pkg::*;

   logic                   req_q;
   logic [SEQID_WIDTH-1:0] short_id_q;
   logic [SEQID_WIDTH-1:0] long_id_q;

   function automatic hdr_type_t pack_hdr(input seq_desc_t d);
      hdr_type_t h;
      h.comp_mode        = d.comp_mode;
      h.lz77_win_size    = d.lz77_win_size;
      h.xp10_prefix_mode = d.xp10_prefix_mode;
      return h;
   endfunction

   // stage one, capture the request.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_q <= 1'b0;
      end else begin
         req_q <= hdr_req;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_req) begin
         short_id_q <= short_seq_id;
         long_id_q  <= long_seq_id;
      end
   end

   assign lk_short_id = short_id_q;
   assign lk_long_id  = long_id_q;

   // stage two, register the lookup results.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hdr_vld <= 1'b0;
      end else begin
         hdr_vld <= req_q;
      end
   end

   always_ff @(posedge clk) begin
      if (req_q) begin
         hdr_short <= pack_hdr(lk_short_desc);
         hdr_long  <= pack_hdr(lk_long_desc);
         hdr_crc   <= lk_short_desc.raw_crc;
         hdr_err   <= !lk_short_vld || !lk_long_vld;
      end
   end

endmodule

// ==== hw/huf_seq_top.sv ====
// top level of the sequence descriptor store.
// frame admission, sequence id table and header builder.

`timescale 1ns/1ps

module huf_seq_top #(
   parameter int SEQID_NUM   = huf_seq_pkg::SEQID_NUM,
   parameter int SEQID_WIDTH = huf_seq_pkg::SEQID_WIDTH
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   frame_start,
   input  huf_seq_pkg::seq_desc_t start_desc,
   input  logic                   crc_in_vld,
   input  logic [SEQID_WIDTH-1:0] crc_in_seq_id,
   input  logic [31:0]            crc_in_value,
   input  logic                   rel_vld,
   input  logic [SEQID_WIDTH-1:0] rel_seq_id,
   input  logic                   hdr_req,
   input  logic [SEQID_WIDTH-1:0] short_seq_id,
   input  logic [SEQID_WIDTH-1:0] long_seq_id,
   output logic                   alloc_vld,
   output logic [SEQID_WIDTH-1:0] alloc_seq_id,
   output logic [15:0]            rej_cnt,
   output logic                   hdr_vld,
   output huf_seq_pkg::hdr_type_t hdr_short,
   output huf_seq_pkg::hdr_type_t hdr_long,
   output logic [31:0]            hdr_crc,
   output logic                   hdr_err
);

   import huf_seq_pkg::*;

   logic                   wr_vld;
   logic [SEQID_WIDTH-1:0] wr_seq_id;
   seq_desc_t              wr_desc;
   logic                   crc_vld;
   logic [SEQID_WIDTH-1:0] crc_seq_id;
   logic [31:0]            crc_value;
   logic [SEQID_NUM-1:0]   seq_vld;
   logic [SEQID_WIDTH-1:0] lk_short_id;
   logic [SEQID_WIDTH-1:0] lk_long_id;
   seq_desc_t              lk_short_desc;
   seq_desc_t              lk_long_desc;
   logic                   lk_short_vld;
   logic                   lk_long_vld;

   seq_admit #(
      .SEQID_NUM   (SEQID_NUM),
      .SEQID_WIDTH (SEQID_WIDTH)
   ) u_seq_admit (
      .clk           (clk),
      .rst_n         (rst_n),
      .frame_start   (frame_start),
      .start_desc    (start_desc),
      .crc_in_vld    (crc_in_vld),
      .crc_in_seq_id (crc_in_seq_id),
      .crc_in_value  (crc_in_value),
      .seq_vld       (seq_vld),
      .wr_vld        (wr_vld),
      .wr_seq_id     (wr_seq_id),
      .wr_desc       (wr_desc),
      .crc_vld       (crc_vld),
      .crc_seq_id    (crc_seq_id),
      .crc_value     (crc_value),
      .alloc_vld     (alloc_vld),
      .alloc_seq_id  (alloc_seq_id),
      .rej_cnt       (rej_cnt)
   );

   seq_id_table #(
      .SEQID_NUM   (SEQID_NUM),
      .SEQID_WIDTH (SEQID_WIDTH)
   ) u_seq_id_table (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_vld        (wr_vld),
      .wr_seq_id     (wr_seq_id),
      .wr_desc       (wr_desc),
      .crc_vld       (crc_vld),
      .crc_seq_id    (crc_seq_id),
      .crc_value     (crc_value),
      .rel_vld       (rel_vld),
      .rel_seq_id    (rel_seq_id),
      .lk_short_id   (lk_short_id),
      .lk_long_id    (lk_long_id),
      .seq_vld       (seq_vld),
      .lk_short_desc (lk_short_desc),
      .lk_long_desc  (lk_long_desc),
      .lk_short_vld  (lk_short_vld),
      .lk_long_vld   (lk_long_vld)
   );

   hdr_builder #(
      .SEQID_WIDTH (SEQID_WIDTH)
   ) u_hdr_builder (
      .clk           (clk),
      .rst_n         (rst_n),
      .hdr_req       (hdr_req),
      .short_seq_id  (short_seq_id),
      .long_seq_id   (long_seq_id),
      .lk_short_desc (lk_short_desc),
      .lk_long_desc  (lk_long_desc),
      .lk_short_vld  (lk_short_vld),
      .lk_long_vld   (lk_long_vld),
      .lk_short_id   (lk_short_id),
      .lk_long_id    (lk_long_id),
      .hdr_vld       (hdr_vld),
      .hdr_short     (hdr_short),
      .hdr_long      (hdr_long),
      .hdr_crc       (hdr_crc),
      .hdr_err       (hdr_err)
   );

endmodule

// ==== dv/huf_seq_properties.sv ====
// concurrent assertions on the top level, bound into huf_seq_top.
// header latency, allocation on a full table, idle outputs after reset.

`timescale 1ns/1ps

module huf_seq_properties #(
   parameter int SEQID_NUM = huf_seq_pkg::SEQID_NUM
) (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 hdr_req,
   input logic                 hdr_vld,
   input logic                 alloc_vld,
   input logic [SEQID_NUM-1:0] seq_vld
);

   // header result exactly two cycles behind the request.
   a_hdr_latency: assert property (@(posedge clk) disable iff (!rst_n)
      hdr_vld == $past(hdr_req, 2))
      else $error("hdr_vld does not follow hdr_req by two cycles");

   a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      (&seq_vld) |-> !alloc_vld)
      else $error("alloc_vld high while every entry is valid");

   // first two edges after reset release.
   a_idle_after_reset: assert property (@(posedge clk)
      (rst_n && (!$past(rst_n) || !$past(rst_n, 2))) |-> (!hdr_vld && !alloc_vld))
      else $error("hdr_vld or alloc_vld high right after reset");

endmodule

// ==== dv/huf_seq_tb.sv ====
// directed testbench for the sequence descriptor store.
// clock, reset, watchdog, scoreboard and one task per test.

`timescale 1ns/1ps

module huf_seq_tb;

   import huf_seq_pkg::*;

   localparam int WATCHDOG_NS = 200 * 6 * 10;

   logic                   clk;
   logic                   rst_n;
   logic                   frame_start;
   seq_desc_t              start_desc;
   logic                   crc_in_vld;
   logic [SEQID_WIDTH-1:0] crc_in_seq_id;
   logic [31:0]            crc_in_value;
   logic                   rel_vld;
   logic [SEQID_WIDTH-1:0] rel_seq_id;
   logic                   hdr_req;
   logic [SEQID_WIDTH-1:0] short_seq_id;
   logic [SEQID_WIDTH-1:0] long_seq_id;
   logic                   alloc_vld;
   logic [SEQID_WIDTH-1:0] alloc_seq_id;
   logic [15:0]            rej_cnt;
   logic                   hdr_vld;
   hdr_type_t              hdr_short;
   hdr_type_t              hdr_long;
   logic [31:0]            hdr_crc;
   logic                   hdr_err;

   // scoreboard of the table.
   seq_desc_t              sb_desc [SEQID_NUM];
   logic [SEQID_NUM-1:0]   sb_vld;
   logic [15:0]            sb_rej;

   hdr_type_t              exp_short_q [$];
   hdr_type_t              exp_long_q [$];
   logic [31:0]            exp_crc_q [$];
   logic                   exp_err_q [$];
   int                     exp_cyc_q [$];
   logic [SEQID_WIDTH-1:0] req_short [16];
   logic [SEQID_WIDTH-1:0] req_long [16];

   integer seed = 32'h81afe58f;
   int     cyc = 0;

   huf_seq_top #(
      .SEQID_NUM   (SEQID_NUM),
      .SEQID_WIDTH (SEQID_WIDTH)
   ) dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .frame_start   (frame_start),
      .start_desc    (start_desc),
      .crc_in_vld    (crc_in_vld),
      .crc_in_seq_id (crc_in_seq_id),
      .crc_in_value  (crc_in_value),
      .rel_vld       (rel_vld),
      .rel_seq_id    (rel_seq_id),
      .hdr_req       (hdr_req),
      .short_seq_id  (short_seq_id),
      .long_seq_id   (long_seq_id),
      .alloc_vld     (alloc_vld),
      .alloc_seq_id  (alloc_seq_id),
      .rej_cnt       (rej_cnt),
      .hdr_vld       (hdr_vld),
      .hdr_short     (hdr_short),
      .hdr_long      (hdr_long),
      .hdr_crc       (hdr_crc),
      .hdr_err       (hdr_err)
   );

   bind huf_seq_top huf_seq_properties #(
      .SEQID_NUM (SEQID_NUM)
   ) u_props (
      .clk       (clk),
      .rst_n     (rst_n),
      .hdr_req   (hdr_req),
      .hdr_vld   (hdr_vld),
      .alloc_vld (alloc_vld),
      .seq_vld   (seq_vld)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_run();
      end
   endtask

   // header word as the rules define it, prefix masked by predet_mem_mask.
   function automatic hdr_type_t model_hdr(input seq_desc_t d);
      hdr_type_t h;
      h.comp_mode        = d.comp_mode;
      h.lz77_win_size    = d.lz77_win_size;
      h.xp10_prefix_mode = d.predet_mem_mask ? d.xp10_prefix_mode : NO_PREFIX;
      return h;
   endfunction

   task automatic make_desc(output seq_desc_t d);
      logic [31:0] r;
      r = $random(seed);
      d.comp_mode        = comp_mode_e'(3'(r[7:0] % 8'd7));
      d.lz77_win_size    = win_size_e'(3'(r[15:8] % 8'd5));
      d.xp10_prefix_mode = prefix_mode_e'(2'(r[23:16] % 8'd3));
      d.predet_mem_mask  = r[24];
      d.raw_crc          = $random(seed);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < SEQID_NUM; i++) begin
         sb_desc[i] = '0;
      end
      sb_vld = '0;
      sb_rej = '0;
      // quiet window after reset.
      repeat (2) @(negedge clk);
   endtask

   // one frame start, expected id is the lowest free scoreboard entry.
   task automatic do_start(input seq_desc_t d);
      logic                   found;
      logic [SEQID_WIDTH-1:0] id;
      found = 1'b0;
      id    = '0;
      for (int i = SEQID_NUM - 1; i >= 0; i--) begin
         if (!sb_vld[i]) begin
            found = 1'b1;
            id    = SEQID_WIDTH'(i);
         end
      end
      @(negedge clk);
      frame_start = 1'b1;
      start_desc  = d;
      #1;
      check("alloc_vld", 64'(alloc_vld), 64'(found));
      if (found) begin
         check("alloc_seq_id", 64'(alloc_seq_id), 64'(id));
      end
      @(negedge clk);
      frame_start = 1'b0;
      if (found) begin
         sb_desc[id] = d;
         sb_vld[id]  = 1'b1;
      end else if (sb_rej != 16'hffff) begin
         sb_rej = sb_rej + 16'd1;
      end
      check("rej_cnt", 64'(rej_cnt), 64'(sb_rej));
   endtask

   task automatic drive_req(input logic [SEQID_WIDTH-1:0] s, input logic [SEQID_WIDTH-1:0] l);
      @(negedge clk);
      hdr_req      = 1'b1;
      short_seq_id = s;
      long_seq_id  = l;
      exp_short_q.push_back(model_hdr(sb_desc[s]));
      exp_long_q.push_back(model_hdr(sb_desc[l]));
      exp_crc_q.push_back(sb_desc[s].raw_crc);
      exp_err_q.push_back(!sb_vld[s] || !sb_vld[l]);
      exp_cyc_q.push_back(cyc);
   endtask

   task automatic collect_hdr();
      int        waited;
      int        ec;
      hdr_type_t es;
      hdr_type_t el;
      waited = 0;
      @(negedge clk);
      while (!hdr_vld && waited < 10) begin
         @(negedge clk);
         waited++;
      end
      if (!hdr_vld) begin
         $display("hdr_vld did not arrive within 10 cycles of a header request");
         stop_run();
      end else begin
         es = exp_short_q.pop_front();
         el = exp_long_q.pop_front();
         ec = exp_cyc_q.pop_front();
         check("hdr latency", 64'(cyc - ec), 64'd2);
         check("hdr_short", 64'(hdr_short), 64'(es));
         check("hdr_long", 64'(hdr_long), 64'(el));
         check("hdr_crc", 64'(hdr_crc), 64'(exp_crc_q.pop_front()));
         check("hdr_err", 64'(hdr_err), 64'(exp_err_q.pop_front()));
      end
   endtask

   // requests on consecutive cycles, results collected in order.
   task automatic run_requests(input int n);
      fork
         begin
            for (int k = 0; k < n; k++) begin
               drive_req(req_short[k], req_long[k]);
            end
            @(negedge clk);
            hdr_req = 1'b0;
         end
         begin
            for (int j = 0; j < n; j++) begin
               collect_hdr();
            end
         end
      join
   endtask

   task automatic test_reset_state();
      seq_desc_t d;
      apply_reset();
      check("rej_cnt", 64'(rej_cnt), 64'd0);
      repeat (3) begin
         @(negedge clk);
         check("hdr_vld", 64'(hdr_vld), 64'd0);
      end
      make_desc(d);
      do_start(d);
   endtask

   task automatic test_fill_table();
      seq_desc_t d;
      apply_reset();
      for (int i = 0; i < SEQID_NUM + 3; i++) begin
         make_desc(d);
         do_start(d);
      end
      check("rej_cnt", 64'(rej_cnt), 64'd3);
   endtask

   task automatic test_hdr_lookup();
      seq_desc_t d;
      apply_reset();
      // odd entries keep their prefix, even ones must read back masked.
      for (int i = 0; i < SEQID_NUM; i++) begin
         make_desc(d);
         d.predet_mem_mask = i[0];
         if (d.xp10_prefix_mode == NO_PREFIX) begin
            d.xp10_prefix_mode = USER_PREFIX;
         end
         do_start(d);
      end
      for (int i = 0; i < SEQID_NUM; i++) begin
         req_short[0] = SEQID_WIDTH'(i);
         req_long[0]  = SEQID_WIDTH'((i + 3) % SEQID_NUM);
         run_requests(1);
      end
   endtask

   task automatic test_crc_update();
      logic [31:0] v;
      v = $random(seed);
      @(negedge clk);
      crc_in_vld    = 1'b1;
      crc_in_seq_id = 3'd5;
      crc_in_value  = v;
      @(negedge clk);
      crc_in_vld = 1'b0;
      sb_desc[5].raw_crc = v;
      req_short[0] = 3'd5;
      req_long[0]  = 3'd2;
      req_short[1] = 3'd2;
      req_long[1]  = 3'd5;
      run_requests(2);
   endtask

   task automatic test_release();
      seq_desc_t d;
      @(negedge clk);
      rel_vld    = 1'b1;
      rel_seq_id = 3'd3;
      @(negedge clk);
      rel_vld   = 1'b0;
      sb_vld[3] = 1'b0;
      req_short[0] = 3'd3;
      req_long[0]  = 3'd1;
      req_short[1] = 3'd1;
      req_long[1]  = 3'd3;
      run_requests(2);
      make_desc(d);
      do_start(d);
      run_requests(1);
   endtask

   task automatic test_pipeline();
      logic [31:0] r;
      for (int k = 0; k < 12; k++) begin
         r = $random(seed);
         req_short[k] = SEQID_WIDTH'(r[15:0] % 16'(SEQID_NUM));
         req_long[k]  = SEQID_WIDTH'(r[31:16] % 16'(SEQID_NUM));
      end
      run_requests(12);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      stop_run();
   end

   initial begin
      rst_n         = 1'b0;
      frame_start   = 1'b0;
      start_desc    = '0;
      crc_in_vld    = 1'b0;
      crc_in_seq_id = '0;
      crc_in_value  = '0;
      rel_vld       = 1'b0;
      rel_seq_id    = '0;
      hdr_req       = 1'b0;
      short_seq_id  = '0;
      long_seq_id   = '0;
      test_reset_state();
      test_fill_table();
      test_hdr_lookup();
      test_crc_update();
      test_release();
      test_pipeline();
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== filelist.f ====
common/huf_seq_pkg.sv
hw/seq_admit.sv
seq_table/seq_id_table.sv
hw/hdr_builder.sv
hw/huf_seq_top.sv
dv/huf_seq_properties.sv
dv/huf_seq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module huf_seq_tb \
   -Mdir obj_dir \
   -o huf_seq_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit $status
fi

./obj_dir/huf_seq_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi
exit 0
